//--- dcache.f
src/dcache_cfg_pkg.sv
src/dcache_if_pkg.sv
src/dcache_line_state.sv
src/dcache_sram.sv
src/dcache_ctrl.sv
src/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb -f dcache.f -o dcache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- dv/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;

    typedef struct packed {
        logic [dcache_cfg_pkg::ADDR_W-1:0] addr;
        logic [31:0]                       wdata;
        logic [3:0]                        strb;
        logic [31:0]                       exp_rdata;
        logic [1:0]                        exp_reads;
        logic                              exp_wb;
        logic [dcache_cfg_pkg::ADDR_W-1:0] wb_addr;
        logic [31:0]                       wb_data;
    } test_entry_t;

    logic                              clk;
    logic                              rst;
    dcache_if_pkg::core_req_t          core_req;
    logic [31:0]                       rdata;
    logic                              stall;
    dcache_if_pkg::mem_req_t           mem_req;
    dcache_if_pkg::mem_rsp_t           mem_rsp;
    int                                rd_count;
    int                                wr_count;
    logic [dcache_cfg_pkg::ADDR_W-1:0] last_wr_addr;
    logic [31:0]                       last_wr_data;

    test_entry_t table_q[$];
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          cycle_cnt = 0;
    int          cycle_limit;

    dcache_top dut (
        .clk_i      (clk),
        .rst_i      (rst),
        .core_req_i (core_req),
        .rdata_o    (rdata),
        .stall_o    (stall),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp)
    );

    dcache_mem_model mem (
        .clk_i          (clk),
        .rst_i          (rst),
        .req_i          (mem_req),
        .rsp_o          (mem_rsp),
        .rd_count_o     (rd_count),
        .wr_count_o     (wr_count),
        .last_wr_addr_o (last_wr_addr),
        .last_wr_data_o (last_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [dcache_cfg_pkg::ADDR_W-1:0] waddr(input logic [7:0] tag,
                                                               input logic [8:0] index);
        return {tag, index};
    endfunction

    // Initial memory contents, same rule as the memory model
    function automatic logic [31:0] mem_word(input logic [dcache_cfg_pkg::ADDR_W-1:0] a);
        return ({15'd0, a} * 32'h0001_0003) ^ 32'hC3A5_5A3C;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] strb);
        logic [31:0] r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = strb[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return r;
    endfunction

    task automatic add_entry(input logic [dcache_cfg_pkg::ADDR_W-1:0] addr,
                             input logic [31:0] wdata, input logic [3:0] strb,
                             input logic [31:0] exp_rdata, input int exp_reads,
                             input logic exp_wb, input logic [dcache_cfg_pkg::ADDR_W-1:0] wb_addr,
                             input logic [31:0] wb_data);
        test_entry_t e;
        e = '{addr, wdata, strb, exp_rdata, exp_reads[1:0], exp_wb, wb_addr, wb_data};
        table_q.push_back(e);
    endtask

    task automatic apply_entry(input int n, input test_entry_t e);
        int rd0;
        int wr0;
        int errs;
        errs = 0;
        @(posedge clk);
        #2;
        core_req = '{sel: 1'b1, addr: e.addr, wdata: e.wdata, strb: e.strb};
        rd0 = rd_count;
        wr0 = wr_count;
        @(negedge clk);
        while (stall) @(negedge clk);
        if (e.strb == '0 && rdata != e.exp_rdata) begin
            $display("Error: %0d ns: test %0d read %h, expected %h", $time, n, rdata, e.exp_rdata);
            errs++;
        end
        if (rd_count - rd0 != int'(e.exp_reads)) begin
            $display("Error: %0d ns: test %0d made %0d memory reads, expected %0d",
                     $time, n, rd_count - rd0, e.exp_reads);
            errs++;
        end
        if (!e.exp_wb && wr_count != wr0) begin
            $display("Error: %0d ns: test %0d made an unexpected memory write", $time, n);
            errs++;
        end
        if (e.exp_wb && (wr_count - wr0 != 1 || last_wr_addr != e.wb_addr ||
                         last_wr_data != e.wb_data)) begin
            $display("Error: %0d ns: test %0d write-back %h:%h, expected %h:%h",
                     $time, n, last_wr_addr, last_wr_data, e.wb_addr, e.wb_data);
            errs++;
        end
        if (errs == 0) begin
            pass_cnt++;
            $display("test %0d ok", n);
        end else begin
            fail_cnt++;
            $display("test %0d failed", n);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        logic [dcache_cfg_pkg::ADDR_W-1:0] a_a;
        logic [dcache_cfg_pkg::ADDR_W-1:0] a_b;
        logic [dcache_cfg_pkg::ADDR_W-1:0] a_c;
        logic [dcache_cfg_pkg::ADDR_W-1:0] a_e;
        logic [dcache_cfg_pkg::ADDR_W-1:0] a_h;
        logic [dcache_cfg_pkg::ADDR_W-1:0] a_j;
        logic [31:0]                       m_c;
        logic [31:0]                       m_e;
        a_a = waddr(8'd1, 9'd10);
        a_b = waddr(8'd2, 9'd20);
        a_c = waddr(8'd3, 9'd30);
        a_e = waddr(8'd4, 9'd31);
        a_h = waddr(8'd9, 9'd30);
        a_j = waddr(8'd11, 9'd31);
        m_c = merge_bytes(mem_word(a_c), 32'hAAAA_00EE, 4'b0001);
        m_e = merge_bytes(mem_word(a_e), 32'h00BB_CC00, 4'b0110);

        // Miss, hit, clean full store, partial stores
        add_entry(a_a, '0, 4'b0000, mem_word(a_a), 1, 1'b0, '0, '0);
        add_entry(a_a, '0, 4'b0000, mem_word(a_a), 0, 1'b0, '0, '0);
        add_entry(a_b, 32'h1234_5678, 4'b1111, '0, 0, 1'b0, '0, '0);
        add_entry(a_b, '0, 4'b0000, 32'h1234_5678, 0, 1'b0, '0, '0);
        add_entry(a_c, 32'hAAAA_00EE, 4'b0001, '0, 1, 1'b0, '0, '0);
        add_entry(a_c, '0, 4'b0000, m_c, 0, 1'b0, '0, '0);
        add_entry(a_e, 32'h00BB_CC00, 4'b0110, '0, 1, 1'b0, '0, '0);
        add_entry(a_e, '0, 4'b0000, m_e, 0, 1'b0, '0, '0);
        add_entry(waddr(8'd5, 9'd32), 32'hDDEE_0000, 4'b1100, '0, 1, 1'b0, '0, '0);
        add_entry(waddr(8'd5, 9'd32), '0, 4'b0000,
                  merge_bytes(mem_word(waddr(8'd5, 9'd32)), 32'hDDEE_0000, 4'b1100),
                  0, 1'b0, '0, '0);
        // Dirty victims are written back, clean ones are dropped
        add_entry(waddr(8'd7, 9'd20), '0, 4'b0000, mem_word(waddr(8'd7, 9'd20)), 1,
                  1'b1, a_b, 32'h1234_5678);
        add_entry(a_b, '0, 4'b0000, 32'h1234_5678, 1, 1'b0, '0, '0);
        add_entry(a_h, 32'h0000_F00D, 4'b0011, '0, 1, 1'b1, a_c, m_c);
        add_entry(a_h, '0, 4'b0000, merge_bytes(mem_word(a_h), 32'h0000_F00D, 4'b0011),
                  0, 1'b0, '0, '0);
        add_entry(a_j, 32'hCAFE_BABE, 4'b1111, '0, 0, 1'b1, a_e, m_e);
        add_entry(a_j, '0, 4'b0000, 32'hCAFE_BABE, 0, 1'b0, '0, '0);
        add_entry(waddr(8'd12, 9'd10), '0, 4'b0000, mem_word(waddr(8'd12, 9'd10)), 1,
                  1'b0, '0, '0);
        cycle_limit = table_q.size() * 20 + 10;

        rst = 1'b1;
        core_req = '0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        if (stall || mem_req.valid) begin
            $display("Error: %0d ns: stall or memory valid high after reset", $time);
            fail_cnt++;
        end else begin
            pass_cnt++;
            $display("reset check ok");
        end

        foreach (table_q[i]) begin
            apply_entry(i, table_q[i]);
        end
        @(posedge clk);
        #2;
        core_req = '0;
        @(negedge clk);

        $display("%0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- dv/dcache_mem_model.sv
`timescale 1ns/100ps

module dcache_mem_model (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  dcache_if_pkg::mem_req_t             req_i,
    output dcache_if_pkg::mem_rsp_t             rsp_o,
    output int                                  rd_count_o,
    output int                                  wr_count_o,
    output logic [dcache_cfg_pkg::ADDR_W-1:0]   last_wr_addr_o,
    output logic [dcache_cfg_pkg::DATA_W-1:0]   last_wr_data_o
);

    logic [dcache_cfg_pkg::DATA_W-1:0] words [1 << dcache_cfg_pkg::ADDR_W];

    logic [31:0]                       lcg_q;
    logic                              busy_q;
    logic [1:0]                        wait_q;
    logic                              ready_q = 1'b0;
    logic [dcache_cfg_pkg::DATA_W-1:0] rdata_q = '0;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Odd multiplier keeps every word distinct
    function automatic logic [31:0] init_word(input logic [dcache_cfg_pkg::ADDR_W-1:0] a);
        return ({15'd0, a} * 32'h0001_0003) ^ 32'hC3A5_5A3C;
    endfunction

    initial begin
        for (int a = 0; a < (1 << dcache_cfg_pkg::ADDR_W); a++) begin
            words[a] = init_word(a[dcache_cfg_pkg::ADDR_W-1:0]);
        end
    end

    assign rsp_o = '{ready: ready_q, rdata: rdata_q};

    always @(posedge clk_i) begin
        ready_q <= 1'b0;
        if (rst_i) begin
            busy_q     <= 1'b0;
            wait_q     <= '0;
            lcg_q      <= 32'd72;
            rd_count_o <= 0;
            wr_count_o <= 0;
        end else if (req_i.valid && !ready_q) begin
            if (!busy_q) begin
                // New request, pick its extra delay
                busy_q <= 1'b1;
                wait_q <= lcg_q[17:16];
                lcg_q  <= lcg_next(lcg_q);
            end else if (wait_q != 2'd0) begin
                wait_q <= wait_q - 2'd1;
            end else begin
                busy_q  <= 1'b0;
                ready_q <= 1'b1;
                if (req_i.wstrb == '0) begin
                    rdata_q    <= words[req_i.addr];
                    rd_count_o <= rd_count_o + 1;
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        if (req_i.wstrb[b]) begin
                            words[req_i.addr][8*b +: 8] = req_i.wdata[8*b +: 8];
                        end
                    end
                    wr_count_o     <= wr_count_o + 1;
                    last_wr_addr_o <= req_i.addr;
                    last_wr_data_o <= req_i.wdata;
                end
            end
        end
    end

endmodule

//--- src/dcache_top.sv
`timescale 1ns/100ps

module dcache_top (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  dcache_if_pkg::core_req_t            core_req_i,
    output logic [dcache_cfg_pkg::DATA_W-1:0]   rdata_o,
    output logic                                stall_o,
    output dcache_if_pkg::mem_req_t             mem_req_o,
    input  dcache_if_pkg::mem_rsp_t             mem_rsp_i
);

    dcache_if_pkg::sram_wr_t             sram_wr;
    dcache_if_pkg::sram_rd_t             sram_rd;
    logic [dcache_cfg_pkg::SRAM_W-1:0]   sram_dout;
    logic [dcache_cfg_pkg::INDEX_W-1:0]  line_index;
    logic                                line_valid;
    logic                                line_dirty;
    logic                                line_upd;
    logic                                upd_valid;
    logic                                upd_dirty;

    dcache_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .core_req_i   (core_req_i),
        .rdata_o      (rdata_o),
        .stall_o      (stall_o),
        .mem_req_o    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i),
        .sram_wr_o    (sram_wr),
        .sram_rd_o    (sram_rd),
        .sram_dout_i  (sram_dout),
        .line_index_o (line_index),
        .line_valid_i (line_valid),
        .line_dirty_i (line_dirty),
        .line_upd_o   (line_upd),
        .line_valid_o (upd_valid),
        .line_dirty_o (upd_dirty)
    );

    dcache_line_state u_line_state (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .index_i (line_index),
        .valid_o (line_valid),
        .dirty_o (line_dirty),
        .upd_i   (line_upd),
        .valid_i (upd_valid),
        .dirty_i (upd_dirty)
    );

    dcache_sram u_sram (
        .clk_i  (clk_i),
        .wr_i   (sram_wr),
        .rd_i   (sram_rd),
        .dout_o (sram_dout)
    );

endmodule

//--- src/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  dcache_if_pkg::core_req_t            core_req_i,
    output logic [dcache_cfg_pkg::DATA_W-1:0]   rdata_o,
    output logic                                stall_o,
    output dcache_if_pkg::mem_req_t             mem_req_o,
    input  dcache_if_pkg::mem_rsp_t             mem_rsp_i,
    output dcache_if_pkg::sram_wr_t             sram_wr_o,
    output dcache_if_pkg::sram_rd_t             sram_rd_o,
    input  logic [dcache_cfg_pkg::SRAM_W-1:0]   sram_dout_i,
    output logic [dcache_cfg_pkg::INDEX_W-1:0]  line_index_o,
    input  logic                                line_valid_i,
    input  logic                                line_dirty_i,
    output logic                                line_upd_o,
    output logic                                line_valid_o,
    output logic                                line_dirty_o
);

    dcache_if_pkg::ctrl_state_e state_q;
    dcache_if_pkg::mem_req_t    mem_req_q;

    logic [dcache_cfg_pkg::DATA_W-1:0]   rdata_q;
    logic [dcache_cfg_pkg::DATA_W-1:0]   fill_data_q;
    logic                                fill_use_q;
    logic                                reread_q;

    logic [dcache_cfg_pkg::INDEX_W-1:0]  req_index;
    logic [dcache_cfg_pkg::TAG_W-1:0]    req_tag;
    logic [dcache_cfg_pkg::TAG_W-1:0]    arr_tag;
    logic [dcache_cfg_pkg::DATA_W-1:0]   arr_data;
    logic [dcache_cfg_pkg::DATA_W-1:0]   merged;
    logic                                is_load;
    logic                                full_mask;
    logic                                hit;
    logic                                evict;

    assign req_index = core_req_i.addr[dcache_cfg_pkg::INDEX_W-1:0];
    assign req_tag   = core_req_i.addr[dcache_cfg_pkg::ADDR_W-1:dcache_cfg_pkg::INDEX_W];
    assign arr_tag   = sram_dout_i[dcache_cfg_pkg::DATA_W +: dcache_cfg_pkg::TAG_W];
    assign arr_data  = sram_dout_i[dcache_cfg_pkg::DATA_W-1:0];

    assign is_load   = core_req_i.strb == '0;
    assign full_mask = &core_req_i.strb;

    // Valid bit masks the compare against an unwritten entry
    assign hit   = line_valid_i && (arr_tag == req_tag);
    assign evict = line_valid_i && line_dirty_i && (arr_tag != req_tag);

    // Strobed bytes from the core, the rest from memory
    always_comb begin
        for (int b = 0; b < dcache_cfg_pkg::STRB_W; b++) begin
            merged[8*b +: 8] = core_req_i.strb[b] ? core_req_i.wdata[8*b +: 8]
                                                  : mem_rsp_i.rdata[8*b +: 8];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= dcache_if_pkg::IDLE;
            mem_req_q  <= '0;
            fill_use_q <= 1'b0;
            reread_q   <= 1'b0;
        end else begin
            case (state_q)
                dcache_if_pkg::IDLE: begin
                    fill_use_q <= 1'b0;
                    if (core_req_i.sel) begin
                        state_q <= dcache_if_pkg::TAG_READ;
                    end
                end
                dcache_if_pkg::TAG_READ: begin
                    if (reread_q) begin
                        // Read of the filled line is in flight
                        reread_q <= 1'b0;
                    end else if (hit) begin
                        state_q <= is_load ? dcache_if_pkg::DONE : dcache_if_pkg::ARRAY_WRITE;
                    end else if (evict) begin
                        // Victim word waits in the write request
                        mem_req_q <= '{valid: 1'b1, addr: {arr_tag, req_index},
                                       wdata: arr_data, wstrb: '1};
                        state_q   <= dcache_if_pkg::MEM_WRITE;
                    end else if (full_mask) begin
                        state_q <= dcache_if_pkg::ARRAY_WRITE;
                    end else begin
                        mem_req_q <= '{valid: 1'b1, addr: core_req_i.addr,
                                       wdata: '0, wstrb: '0};
                        state_q   <= dcache_if_pkg::MEM_READ;
                    end
                end
                dcache_if_pkg::MEM_WRITE: begin
                    if (mem_rsp_i.ready) begin
                        if (full_mask) begin
                            mem_req_q.valid <= 1'b0;
                            state_q         <= dcache_if_pkg::ARRAY_WRITE;
                        end else begin
                            mem_req_q <= '{valid: 1'b1, addr: core_req_i.addr,
                                           wdata: '0, wstrb: '0};
                            state_q   <= dcache_if_pkg::MEM_READ;
                        end
                    end
                end
                dcache_if_pkg::MEM_READ: begin
                    if (mem_rsp_i.ready) begin
                        mem_req_q.valid <= 1'b0;
                        fill_use_q      <= 1'b1;
                        state_q         <= dcache_if_pkg::ARRAY_WRITE;
                    end
                end
                dcache_if_pkg::ARRAY_WRITE: begin
                    fill_use_q <= 1'b0;
                    if (is_load) begin
                        reread_q <= 1'b1;
                        state_q  <= dcache_if_pkg::TAG_READ;
                    end else begin
                        state_q <= dcache_if_pkg::DONE;
                    end
                end
                dcache_if_pkg::DONE: begin
                    state_q <= dcache_if_pkg::IDLE;
                end
                default: begin
                    state_q <= dcache_if_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == dcache_if_pkg::TAG_READ && !reread_q && hit) begin
            rdata_q <= arr_data;
        end
        // A load has no strobed bytes and takes the memory word whole
        if (state_q == dcache_if_pkg::MEM_READ && mem_rsp_i.ready) begin
            fill_data_q <= merged;
        end
    end

    always_comb begin
        sram_rd_o.en   = (state_q == dcache_if_pkg::IDLE && core_req_i.sel) ||
                         (state_q == dcache_if_pkg::TAG_READ && reread_q);
        sram_rd_o.addr = req_index;

        sram_wr_o.en    = state_q == dcache_if_pkg::ARRAY_WRITE;
        sram_wr_o.addr  = req_index;
        sram_wr_o.wmask = fill_use_q ? '1 : {1'b1, core_req_i.strb};
        sram_wr_o.din   = {1'b0, req_tag, fill_use_q ? fill_data_q : core_req_i.wdata};

        // Loads fill clean, stores leave the line dirty
        line_upd_o   = state_q == dcache_if_pkg::ARRAY_WRITE;
        line_valid_o = 1'b1;
        line_dirty_o = !is_load;
    end

    assign line_index_o = req_index;
    assign mem_req_o    = mem_req_q;
    assign rdata_o      = rdata_q;
    assign stall_o      = core_req_i.sel && (state_q != dcache_if_pkg::DONE);

    mem_valid_state_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        mem_req_o.valid |->
            state_q inside {dcache_if_pkg::MEM_READ, dcache_if_pkg::MEM_WRITE}
    );

    mem_req_stable_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        mem_req_o.valid && !mem_rsp_i.ready |=> $stable(mem_req_o)
    );

    sram_no_collide_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        sram_wr_o.en && sram_rd_o.en |-> sram_wr_o.addr != sram_rd_o.addr
    );

endmodule

//--- src/dcache_sram.sv
`timescale 1ns/100ps

module dcache_sram (
    input  logic                                clk_i,
    input  dcache_if_pkg::sram_wr_t             wr_i,
    input  dcache_if_pkg::sram_rd_t             rd_i,
    output logic [dcache_cfg_pkg::SRAM_W-1:0]   dout_o
);

    logic [dcache_cfg_pkg::SRAM_W-1:0] mem_q [dcache_cfg_pkg::SETS];

    always_ff @(posedge clk_i) begin
        if (wr_i.en) begin
            for (int b = 0; b < dcache_cfg_pkg::STRB_W; b++) begin
                if (wr_i.wmask[b]) begin
                    mem_q[wr_i.addr][8*b +: 8] <= wr_i.din[8*b +: 8];
                end
            end
            // Tag and spare bit go together
            if (wr_i.wmask[dcache_cfg_pkg::STRB_W]) begin
                mem_q[wr_i.addr][dcache_cfg_pkg::SRAM_W-1:dcache_cfg_pkg::DATA_W] <=
                    wr_i.din[dcache_cfg_pkg::SRAM_W-1:dcache_cfg_pkg::DATA_W];
            end
        end
        if (rd_i.en) begin
            dout_o <= mem_q[rd_i.addr];
        end
    end

    wr_addr_known_a: assert property (
        @(posedge clk_i)
        wr_i.en |-> !$isunknown(wr_i.addr)
    );

    rd_addr_known_a: assert property (
        @(posedge clk_i)
        rd_i.en |-> !$isunknown(rd_i.addr)
    );

endmodule

//--- src/dcache_line_state.sv
`timescale 1ns/100ps

module dcache_line_state (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [dcache_cfg_pkg::INDEX_W-1:0]  index_i,
    output logic                                valid_o,
    output logic                                dirty_o,
    input  logic                                upd_i,
    input  logic                                valid_i,
    input  logic                                dirty_i
);

    logic [dcache_cfg_pkg::SETS-1:0] valid_q;
    logic [dcache_cfg_pkg::SETS-1:0] dirty_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (upd_i) begin
            valid_q[index_i] <= valid_i;
            dirty_q[index_i] <= dirty_i;
        end
    end

    // Lookup is combinational so the controller sees it with the tag read
    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_q[index_i];

    dirty_implies_valid_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (dirty_q & ~valid_q) == '0
    );

endmodule

//--- src/dcache_if_pkg.sv
package dcache_if_pkg;

    // Core side request, strb of zero is a load
    typedef struct packed {
        logic                                sel;
        logic [dcache_cfg_pkg::ADDR_W-1:0]   addr;
        logic [dcache_cfg_pkg::DATA_W-1:0]   wdata;
        logic [dcache_cfg_pkg::STRB_W-1:0]   strb;
    } core_req_t;

    // Memory request, wstrb of zero is a read
    typedef struct packed {
        logic                                valid;
        logic [dcache_cfg_pkg::ADDR_W-1:0]   addr;
        logic [dcache_cfg_pkg::DATA_W-1:0]   wdata;
        logic [dcache_cfg_pkg::STRB_W-1:0]   wstrb;
    } mem_req_t;

    typedef struct packed {
        logic                                ready;
        logic [dcache_cfg_pkg::DATA_W-1:0]   rdata;
    } mem_rsp_t;

    // wmask msb enables the tag field
    typedef struct packed {
        logic                                en;
        logic [dcache_cfg_pkg::INDEX_W-1:0]  addr;
        logic [dcache_cfg_pkg::STRB_W:0]     wmask;
        logic [dcache_cfg_pkg::SRAM_W-1:0]   din;
    } sram_wr_t;

    typedef struct packed {
        logic                                en;
        logic [dcache_cfg_pkg::INDEX_W-1:0]  addr;
    } sram_rd_t;

    typedef enum logic [2:0] {
        IDLE,
        TAG_READ,
        ARRAY_WRITE,
        MEM_READ,
        MEM_WRITE,
        DONE
    } ctrl_state_e;

endpackage

//--- src/dcache_cfg_pkg.sv
package dcache_cfg_pkg;

    // Word address, byte address bits 18:2
    localparam int unsigned ADDR_W = 17;

    // Byte address bits 18:11
    localparam int unsigned TAG_W = 8;

    // Byte address bits 10:2
    localparam int unsigned INDEX_W = 9;

    localparam int unsigned SETS = 512;

    localparam int unsigned DATA_W = 32;
    localparam int unsigned STRB_W = 4;

    // Spare bit, tag, data
    localparam int unsigned SRAM_W = 41;

endpackage
